// ==== bus_port_router.sv ====
`timescale 1ns/1ps

module bus_port_router (
	input	logic						clk85m,
	input	logic						arst_n,
	input	vdp_cart_pkg::bus_req_t		up_req,
	input	logic						up_valid,
	output	logic						up_ready,
	output	logic	[7:0]				up_rdata,
	output	logic						up_rdata_en,
	output	logic						ctrl_valid,
	input	logic						ctrl_ready,
	input	logic	[7:0]				ctrl_rdata,
	input	logic						ctrl_rdata_en,
	output	logic						data_valid,
	input	logic						data_ready,
	input	logic	[7:0]				data_rdata,
	input	logic						data_rdata_en
);
	import vdp_cart_pkg::*;

	logic	[7:0]	offset;			// address relative to 0x98
	logic			sel_ctrl;
	logic			sel_data;
	logic			unmapped;
	logic			ff_unm_ack;		// own ready for unclaimed ports
	logic			ff_unm_rd;		// own rdata_en, reads only

	// ----------------------------------------------------------
	// port decode
	// ----------------------------------------------------------
	assign offset	= up_req.address - vdp_port_base;
	assign sel_data	= (offset[7:2] == 6'd0) && (offset[1:0] == data_port_ofs);
	assign sel_ctrl	= (offset[7:2] == 6'd0) && (offset[1:0] == ctrl_port_ofs);
	assign unmapped	= ~sel_data & ~sel_ctrl;		// 0x9a, 0x9b and out of range

	assign ctrl_valid	= up_valid & sel_ctrl;
	assign data_valid	= up_valid & sel_data;

	// ----------------------------------------------------------
	// unmapped responder
	// ----------------------------------------------------------
	always_ff @(posedge clk85m or negedge arst_n) begin
		if (!arst_n) begin
			ff_unm_ack	<= 1'b0;
			ff_unm_rd	<= 1'b0;
		end else begin
			ff_unm_ack	<= up_valid & unmapped & ~ff_unm_ack;		// single pulse
			ff_unm_rd	<= up_valid & unmapped & ~ff_unm_ack & ~up_req.write;
		end
	end

	// ----------------------------------------------------------
	// response merge
	// ----------------------------------------------------------
	assign up_ready		= ctrl_ready | data_ready | ff_unm_ack;
	assign up_rdata_en	= ctrl_rdata_en | data_rdata_en | ff_unm_rd;

	always_comb begin
		if (ctrl_rdata_en) begin
			up_rdata = ctrl_rdata;
		end else if (data_rdata_en) begin
			up_rdata = data_rdata;
		end else begin
			up_rdata = unmapped_rdata;			// also the idle value
		end
	end

endmodule

// ==== msx_slot_bridge.sv ====
`timescale 1ns/1ps

module msx_slot_bridge (
	input	logic						clk85m,
	input	logic						arst_n,
	input	logic						slot_iorq_n,
	input	logic						slot_rd_n,
	input	logic						slot_wr_n,
	input	logic	[7:0]				slot_a,
	input	logic	[7:0]				slot_d_in,
	output	logic	[7:0]				slot_d_out,
	output	logic						slot_data_dir,	// 1 = cartridge drives d
	output	logic						slot_wait,
	output	vdp_cart_pkg::bus_req_t		bus_req,
	output	logic						bus_valid,
	input	logic						bus_ready,
	input	logic	[7:0]				bus_rdata,
	input	logic						bus_rdata_en
);
	import vdp_cart_pkg::*;

	typedef enum logic [1:0] {
		st_idle,		// no slot cycle
		st_req,			// request held on the bus
		st_data,		// read accepted but no data yet
		st_release		// wait for strobes high
	} state_t;

	logic	[1:0]	ff_iorq_s;		// 2-ff sync chains
	logic	[1:0]	ff_rd_s;
	logic	[1:0]	ff_wr_s;
	state_t			ff_state;
	logic			ff_valid;
	logic			ff_wait;
	logic			ff_dir;
	logic	[7:0]	ff_dout;		// read data to slot
	bus_req_t		ff_req;
	logic			rd_act;
	logic			wr_act;
	logic			cyc_act;

	// ----------------------------------------------------------
	// strobe synchronizers
	// ----------------------------------------------------------
	always_ff @(posedge clk85m or negedge arst_n) begin
		if (!arst_n) begin
			ff_iorq_s	<= 2'b11;			// strobes idle high
			ff_rd_s		<= 2'b11;
			ff_wr_s		<= 2'b11;
		end else begin
			ff_iorq_s	<= {ff_iorq_s[0], slot_iorq_n};
			ff_rd_s		<= {ff_rd_s[0], slot_rd_n};
			ff_wr_s		<= {ff_wr_s[0], slot_wr_n};
		end
	end

	assign rd_act	= ~ff_rd_s[1];
	assign wr_act	= ~ff_wr_s[1];
	assign cyc_act	= ~ff_iorq_s[1] & (rd_act | wr_act);	// i/o cycle in progress

	// ----------------------------------------------------------
	// cycle fsm
	// ----------------------------------------------------------
	always_ff @(posedge clk85m or negedge arst_n) begin
		if (!arst_n) begin
			ff_state	<= st_idle;
			ff_valid	<= 1'b0;
			ff_wait		<= 1'b0;
			ff_dir		<= 1'b0;
		end else begin
			case (ff_state)
				st_idle: if (cyc_act) begin
					ff_valid	<= 1'b1;		// 3rd cycle after strobe
					ff_wait		<= 1'b1;		// stall the z80 with valid
					ff_state	<= st_req;
				end
				st_req: if (bus_ready) begin
					ff_valid	<= 1'b0;
					if (ff_req.write || bus_rdata_en) begin
						ff_wait		<= 1'b0;	// done this cycle
						ff_state	<= st_release;
					end else begin
						ff_state	<= st_data;	// data comes later
					end
				end
				st_data: if (bus_rdata_en) begin
					ff_wait		<= 1'b0;
					ff_state	<= st_release;
				end
				st_release: if (!cyc_act) ff_state <= st_idle;
				default: ff_state <= st_idle;
			endcase
			if (bus_rdata_en) ff_dir <= 1'b1;		// drive until rd_n rises
			else if (!rd_act) ff_dir <= 1'b0;
		end
	end

	always_ff @(posedge clk85m) begin
		if (ff_state == st_idle && cyc_act) begin
			ff_req <= '{address: slot_a, write: wr_act, wdata: slot_d_in};
		end
		if (bus_rdata_en) ff_dout <= bus_rdata;	// hold for the slot
	end

	assign bus_req			= ff_req;
	assign bus_valid		= ff_valid;
	assign slot_wait		= ff_wait;
	assign slot_data_dir	= ff_dir;
	assign slot_d_out		= ff_dout;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_vdp_io_subsystem

out=$(./obj_dir/Vtb_vdp_io_subsystem)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TESTS PASSED'; then
	exit 0
else
	exit 1
fi

// ==== sources.f ====
vdp_cart_pkg.sv
vram_mem.sv
msx_slot_bridge.sv
bus_port_router.sv
vdp_ctrl_port.sv
vram_data_port.sv
vdp_io_subsystem.sv
tb_vdp_io_subsystem.sv

// ==== tb_vdp_io_subsystem.sv ====
`timescale 1ns/1ps

module tb_vdp_io_subsystem;
	import vdp_cart_pkg::*;

	localparam logic [7:0]	data_port			= vdp_port_base;			// 0x98
	localparam logic [7:0]	ctrl_port			= vdp_port_base + 8'd1;		// 0x99
	localparam int			cycles_per_access	= 30;
	localparam int			access_budget		= 700;
	localparam int			timeout_cycles		= cycles_per_access * access_budget;
	localparam int			wait_rise_cycles	= 3;		// 2-ff sync plus request flop

	logic			clk85m;
	logic			arst_n;
	logic			slot_iorq_n;
	logic			slot_rd_n;
	logic			slot_wr_n;
	logic	[7:0]	slot_a;
	logic	[7:0]	slot_d_in;
	logic	[7:0]	slot_d_out;
	logic			slot_data_dir;
	logic			slot_wait;
	vdp_regs_t		regs;

	logic	[7:0]	ref_mem [0:(1 << vram_addr_w) - 1];		// vram model
	bit				ref_known [0:(1 << vram_addr_w) - 1];	// byte written yet
	logic	[7:0]	ref_regs [0:15];
	logic			ref_latch_full;
	logic	[7:0]	ref_latch;
	logic	[16:0]	ref_addr;
	logic	[7:0]	ref_buf;			// read-ahead copy
	logic			ref_buf_known;

	logic	[7:0]	cmp_port;			// last access, handed to the checker
	logic	[7:0]	cmp_got;
	logic	[7:0]	cmp_exp;
	logic			cmp_rd;
	logic			cmp_known;
	logic			cmp_dir;
	int				cmp_wait_lat;		// strobe to slot_wait high
	vdp_regs_t		cmp_regs;
	int				cmp_seq;
	int				cmp_seen;
	int				check_count;
	int				err_count;
	int				err_mark;
	int				access_count;
	int				acc_mark;
	int				test_count;
	int				cycle_count;
	logic	[31:0]	rng_state = 32'd43;

	vdp_io_subsystem i_dut (
		.clk85m, .arst_n, .slot_iorq_n, .slot_rd_n, .slot_wr_n, .slot_a,
		.slot_d_in, .slot_d_out, .slot_data_dir, .slot_wait, .regs
	);

	initial begin
		clk85m = 1'b0;
		forever #10 clk85m = ~clk85m;			// 50 MHz stand-in
	end

	// ------------------------------------------------------------
	// reference model and helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic roll(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	// returns {compare_valid, expected read byte}
	function automatic logic [8:0] ref_io(input logic [7:0] port, input logic is_write,
		input logic [7:0] wdata);
		logic	[8:0]	res;
		logic	[16:0]	la;
		res = 9'h000;
		if (port == data_port) begin
			if (is_write) begin
				ref_mem[ref_addr]	= wdata;
				ref_known[ref_addr]	= 1'b1;
				ref_buf				= wdata;		// write lands in the buffer too
				ref_buf_known		= 1'b1;
			end else begin
				res				= {ref_buf_known, ref_buf};
				ref_buf			= ref_mem[ref_addr];	// refill from counter
				ref_buf_known	= ref_known[ref_addr];
			end
			ref_addr = ref_addr + 17'd1;			// wraps at 128 KB
		end else if (port == ctrl_port) begin
			if (!is_write) begin
				res				= {1'b1, 8'h00};	// no display flags
				ref_latch_full	= 1'b0;
			end else if (!ref_latch_full) begin
				ref_latch		= wdata;
				ref_latch_full	= 1'b1;
			end else begin
				ref_latch_full = 1'b0;
				if (wdata[7]) begin
					ref_regs[wdata[3:0]] = ref_latch;	// only 0-7 and 14 visible
				end else begin
					la = {ref_regs[14][2:0], wdata[5:0], ref_latch};
					if (wdata[6]) begin
						ref_addr = la;					// write mode
					end else begin
						ref_buf			= ref_mem[la];	// read mode prefetch
						ref_buf_known	= ref_known[la];
						ref_addr		= la + 17'd1;
					end
				end
			end
		end else if (!is_write) begin
			res = {1'b1, 8'hFF};					// floating bus
		end
		return res;
	endfunction

	function automatic vdp_regs_t expected_regs();
		vdp_regs_t r;
		r.r0	= ref_regs[0];
		r.r1	= ref_regs[1];
		r.r2	= ref_regs[2];
		r.r3	= ref_regs[3];
		r.r4	= ref_regs[4];
		r.r5	= ref_regs[5];
		r.r6	= ref_regs[6];
		r.r7	= ref_regs[7];
		r.r14	= ref_regs[14];
		return r;
	endfunction

	task automatic check_value(input string name, input logic [71:0] got,
		input logic [71:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERROR %s got 0x%0h expected 0x%0h (port 0x%02h, access %0d)",
				name, got, exp, cmp_port, access_count);
		end
	endtask

	// ------------------------------------------------------------
	// slot cycles
	// ------------------------------------------------------------
	task automatic io_access(input logic [7:0] port, input logic is_write,
		input logic [7:0] wdata);
		logic	[8:0]	exp;
		logic	[7:0]	got;
		logic			dir;
		int				lat;
		@(posedge clk85m);
		slot_a		<= port;
		slot_d_in	<= is_write ? wdata : 8'h00;
		slot_iorq_n	<= 1'b0;
		if (is_write) slot_wr_n <= 1'b0;
		else slot_rd_n <= 1'b0;
		@(posedge clk85m);
		lat = 0;
		while (slot_wait !== 1'b1) begin			// bridge picked it up
			@(posedge clk85m);
			lat++;
		end
		while (slot_wait !== 1'b0) @(posedge clk85m);	// transfer over
		got	= slot_d_out;
		dir	= slot_data_dir;
		slot_iorq_n	<= 1'b1;
		slot_rd_n	<= 1'b1;
		slot_wr_n	<= 1'b1;
		exp = ref_io(port, is_write, wdata);
		cmp_port		<= port;
		cmp_rd			<= ~is_write;
		cmp_known		<= exp[8];
		cmp_exp			<= exp[7:0];
		cmp_got			<= got;
		cmp_dir			<= dir;
		cmp_wait_lat	<= lat;
		cmp_regs		<= expected_regs();
		cmp_seq			<= cmp_seq + 1;
		access_count++;
		repeat (3) @(posedge clk85m);			// strobes back high
	endtask

	task automatic io_write(input logic [7:0] port, input logic [7:0] wdata);
		io_access(port, 1'b1, wdata);
	endtask

	task automatic io_read(input logic [7:0] port);
		io_access(port, 1'b0, 8'h00);
	endtask

	task automatic set_register(input logic [3:0] idx, input logic [7:0] val);
		io_write(ctrl_port, val);
		io_write(ctrl_port, {4'h8, idx});
	endtask

	task automatic load_vram_addr(input logic [16:0] a, input logic wr_mode);
		set_register(4'd14, {5'd0, a[16:14]});		// bank bits
		io_write(ctrl_port, a[7:0]);
		io_write(ctrl_port, {1'b0, wr_mode, a[13:8]});
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("test %0d %s: %0d accesses, %0d errors", test_count, name,
			access_count - acc_mark, err_count - err_mark);
		acc_mark = access_count;
		err_mark = err_count;
	endtask

	// one compare per finished access
	always @(posedge clk85m) begin
		if (cmp_seq != cmp_seen) begin
			cmp_seen <= cmp_seq;
			if (cmp_rd && cmp_known) check_value("slot_d_out", 72'(cmp_got), 72'(cmp_exp));
			check_value("slot_data_dir", 72'(cmp_dir), 72'(cmp_rd));
			check_value("slot_wait", 72'(cmp_wait_lat), 72'(wait_rise_cycles));
			check_value("regs", 72'(regs), 72'(cmp_regs));
		end
	end

	initial begin
		while (cycle_count < timeout_cycles) begin
			@(posedge clk85m);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d cycles", timeout_cycles);
		$display("TESTS FAILED");
		$finish;
	end

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		logic	[31:0]	r;
		logic	[3:0]	idx;
		logic	[7:0]	val;
		logic	[7:0]	port;
		arst_n		= 1'b0;
		slot_iorq_n	= 1'b1;
		slot_rd_n	= 1'b1;
		slot_wr_n	= 1'b1;
		slot_a		= 8'h00;
		slot_d_in	= 8'h00;
		ref_latch_full	= 1'b0;
		ref_latch		= 8'h00;
		ref_addr		= 17'd0;
		ref_buf			= 8'h00;
		ref_buf_known	= 1'b0;					// buffer empty after reset
		for (int i = 0; i < 16; i++) ref_regs[i] = 8'h00;
		repeat (3) @(posedge clk85m);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk85m);

		io_read(8'h9A);							// unmapped ports
		io_read(8'h9B);
		io_read(8'h10);
		io_read(8'hFF);
		io_write(8'h9A, 8'h12);
		io_write(8'h9B, 8'h34);
		io_write(8'h00, 8'h56);
		end_test("unmapped ports");

		for (int i = 0; i < 8; i++) set_register(4'(i), 8'(i * 37 + 3));
		set_register(4'd14, 8'h05);
		set_register(4'd9, 8'hA5);				// not stored
		set_register(4'd14, 8'h00);
		end_test("register writes");

		load_vram_addr(17'h00340, 1'b1);
		for (int i = 0; i < 64; i++) begin
			roll(r);
			io_write(data_port, r[7:0]);
		end
		load_vram_addr(17'h00340, 1'b0);
		for (int i = 0; i < 64; i++) io_read(data_port);
		end_test("burst write and read-back");

		load_vram_addr(17'h1FFFC, 1'b1);		// top of bank 7
		for (int i = 0; i < 8; i++) io_write(data_port, 8'(8'hC0 + i));
		load_vram_addr(17'h1FFFC, 1'b0);
		for (int i = 0; i < 8; i++) io_read(data_port);
		load_vram_addr(17'h00000, 1'b0);
		for (int i = 0; i < 4; i++) io_read(data_port);
		load_vram_addr(17'h0C123, 1'b1);		// bank 3
		for (int i = 0; i < 4; i++) io_write(data_port, 8'(8'h70 + i));
		load_vram_addr(17'h0C123, 1'b0);
		for (int i = 0; i < 4; i++) io_read(data_port);
		set_register(4'd14, 8'h00);
		end_test("banks and wrap");

		load_vram_addr(17'h00350, 1'b1);
		io_write(data_port, 8'h5A);
		io_read(data_port);						// buffered written byte
		io_read(data_port);
		io_write(ctrl_port, 8'h55);
		io_read(ctrl_port);						// status read drops the latch
		io_write(ctrl_port, 8'hAA);
		io_write(ctrl_port, 8'h83);				// new pair, r3
		end_test("buffer and latch reset");

		while (access_count - acc_mark < 500) begin
			roll(r);
			case (r[2:0])
				3'd0, 3'd1: io_read(data_port);
				3'd2: io_write(data_port, r[15:8]);
				3'd3: begin
					idx = r[11:8];
					val = (idx == 4'd14) ? {7'd0, r[16]} : r[23:16];	// banks 0 and 1
					set_register(idx, val);
				end
				3'd4: begin
					io_write(ctrl_port, r[15:8]);
					io_write(ctrl_port, {1'b0, r[16], 6'h03});	// near 0x03xx
				end
				3'd5: io_read(ctrl_port);
				3'd6: begin
					case (r[9:8])
						2'd0:		port = 8'h9A;
						2'd1:		port = 8'h9B;
						default:	port = r[23:16];
					endcase
					if (port == data_port || port == ctrl_port) port = 8'h40;
					io_access(port, r[16], r[31:24]);
				end
				default: io_write(ctrl_port, r[15:8]);	// lone control byte
			endcase
		end
		end_test("random mixed accesses");

		$display("summary: %0d tests, %0d accesses, %0d checks, %0d errors",
			test_count, access_count, check_count, err_count);
		if (err_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== vdp_cart_pkg.sv ====
package vdp_cart_pkg;

	// ----------------------------------------------------------
	// i/o map
	// ----------------------------------------------------------
	localparam logic [7:0]	vdp_port_base	= 8'h98;	// data port, ctrl port is +1
	localparam logic [1:0]	data_port_ofs	= 2'd0;		// port 0x98
	localparam logic [1:0]	ctrl_port_ofs	= 2'd1;		// port 0x99

	localparam logic [7:0]	unmapped_rdata	= 8'hFF;	// floating bus value
	localparam logic [7:0]	status_rdata	= 8'h00;	// no display flags here

	// ----------------------------------------------------------
	// vram
	// ----------------------------------------------------------
	localparam int			vram_addr_w		= 17;		// 128 KB
	localparam int			vram_latency	= 2;		// read valid to rdata_en

	// ----------------------------------------------------------
	// internal byte bus
	// ----------------------------------------------------------
	typedef struct packed {
		logic	[7:0]	address;		// full z80 i/o address
		logic			write;			// 1 = out, 0 = in
		logic	[7:0]	wdata;			// don't care on reads
	} bus_req_t;

	// vram side request from the data port
	typedef struct packed {
		logic	[vram_addr_w-1:0]	addr;
		logic						write;
		logic	[7:0]				wdata;
	} vram_req_t;

	// address load from the control port
	typedef struct packed {
		logic	[vram_addr_w-1:0]	addr;
		logic						read_mode;	// prefetch on load
	} vram_load_t;

	// register file for the display engine
	typedef struct packed {
		logic	[7:0]	r0;
		logic	[7:0]	r1;
		logic	[7:0]	r2;
		logic	[7:0]	r3;
		logic	[7:0]	r4;
		logic	[7:0]	r5;
		logic	[7:0]	r6;
		logic	[7:0]	r7;
		logic	[7:0]	r14;		// vram bank, a16..a14
	} vdp_regs_t;

endpackage

// ==== vdp_ctrl_port.sv ====
`timescale 1ns/1ps

module vdp_ctrl_port (
	input	logic							clk85m,
	input	logic							arst_n,
	input	vdp_cart_pkg::bus_req_t			req,
	input	logic							valid,
	output	logic							ready,
	output	logic	[7:0]					rdata,
	output	logic							rdata_en,
	output	logic							load,
	output	vdp_cart_pkg::vram_load_t		load_info,
	input	logic							prefetch_busy,
	output	vdp_cart_pkg::vdp_regs_t		regs
);
	import vdp_cart_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_load,		// load pulse out
		st_busy			// wait for the prefetch
	} state_t;

	state_t			ff_state;
	logic			ff_ready;
	logic			ff_rdata_en;
	logic			ff_latch_full;		// first byte held
	logic	[7:0]	ff_latch;
	logic			ff_load;
	vram_load_t		ff_load_info;
	vdp_regs_t		ff_regs;
	logic			acc;

	assign acc = valid & ~ff_ready & (ff_state == st_idle);	// new access this cycle

	// ----------------------------------------------------------
	// two-byte sequence
	// ----------------------------------------------------------
	always_ff @(posedge clk85m or negedge arst_n) begin
		if (!arst_n) begin
			ff_state		<= st_idle;
			ff_ready		<= 1'b0;
			ff_rdata_en		<= 1'b0;
			ff_latch_full	<= 1'b0;
			ff_load			<= 1'b0;
			ff_regs			<= '0;
		end else begin
			ff_ready	<= 1'b0;
			ff_rdata_en	<= acc & ~req.write;		// status read
			ff_load		<= 1'b0;
			case (ff_state)
				st_idle: if (acc) begin
					if (!req.write) begin
						ff_ready		<= 1'b1;
						ff_latch_full	<= 1'b0;		// status read resets the latch
					end else if (!ff_latch_full) begin
						ff_ready		<= 1'b1;
						ff_latch_full	<= 1'b1;
					end else if (req.wdata[7]) begin
						ff_ready		<= 1'b1;		// register write
						ff_latch_full	<= 1'b0;
						case (req.wdata[3:0])
							4'd0:		ff_regs.r0	<= ff_latch;
							4'd1:		ff_regs.r1	<= ff_latch;
							4'd2:		ff_regs.r2	<= ff_latch;
							4'd3:		ff_regs.r3	<= ff_latch;
							4'd4:		ff_regs.r4	<= ff_latch;
							4'd5:		ff_regs.r5	<= ff_latch;
							4'd6:		ff_regs.r6	<= ff_latch;
							4'd7:		ff_regs.r7	<= ff_latch;
							4'd14:		ff_regs.r14	<= ff_latch;
							default:	;				// not stored here
						endcase
					end else if (!prefetch_busy) begin
						ff_load			<= 1'b1;		// address load
						ff_latch_full	<= 1'b0;
						ff_state		<= st_load;
					end
				end
				st_load: ff_state <= st_busy;			// busy visible from here
				st_busy: if (!prefetch_busy) begin
					ff_ready	<= 1'b1;
					ff_state	<= st_idle;
				end
				default: ff_state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk85m) begin
		if (acc && req.write && !ff_latch_full) ff_latch <= req.wdata;
		if (acc && req.write && ff_latch_full) begin
			ff_load_info <= '{addr: {ff_regs.r14[2:0], req.wdata[5:0], ff_latch},
				read_mode: ~req.wdata[6]};
		end
	end

	assign ready		= ff_ready;
	assign rdata_en		= ff_rdata_en;
	assign rdata		= status_rdata;
	assign load			= ff_load;
	assign load_info	= ff_load_info;
	assign regs			= ff_regs;

endmodule

// ==== vdp_io_subsystem.sv ====
`timescale 1ns/1ps

module vdp_io_subsystem (
	input	logic						clk85m,
	input	logic						arst_n,
	input	logic						slot_iorq_n,
	input	logic						slot_rd_n,
	input	logic						slot_wr_n,
	input	logic	[7:0]				slot_a,
	input	logic	[7:0]				slot_d_in,
	output	logic	[7:0]				slot_d_out,
	output	logic						slot_data_dir,
	output	logic						slot_wait,
	output	vdp_cart_pkg::vdp_regs_t	regs
);
	import vdp_cart_pkg::*;

	bus_req_t		w_bus_req;			// shared by router and ports
	logic			w_bus_valid;
	logic			w_bus_ready;
	logic	[7:0]	w_bus_rdata;
	logic			w_bus_rdata_en;
	logic			w_ctrl_valid;
	logic			w_ctrl_ready;
	logic	[7:0]	w_ctrl_rdata;
	logic			w_ctrl_rdata_en;
	logic			w_data_valid;
	logic			w_data_ready;
	logic	[7:0]	w_data_rdata;
	logic			w_data_rdata_en;
	logic			w_load;
	vram_load_t		w_load_info;
	logic			w_prefetch_busy;
	vram_req_t		w_vram_req;
	logic			w_vram_valid;
	logic	[7:0]	w_vram_rdata;
	logic			w_vram_rdata_en;

	// ----------------------------------------------------------
	// slot side
	// ----------------------------------------------------------
	msx_slot_bridge u_bridge (
		.clk85m, .arst_n, .slot_iorq_n, .slot_rd_n, .slot_wr_n, .slot_a,
		.slot_d_in, .slot_d_out, .slot_data_dir, .slot_wait,
		.bus_req		(w_bus_req),
		.bus_valid		(w_bus_valid),
		.bus_ready		(w_bus_ready),
		.bus_rdata		(w_bus_rdata),
		.bus_rdata_en	(w_bus_rdata_en)
	);

	bus_port_router u_router (
		.clk85m, .arst_n,
		.up_req			(w_bus_req),
		.up_valid		(w_bus_valid),
		.up_ready		(w_bus_ready),
		.up_rdata		(w_bus_rdata),
		.up_rdata_en	(w_bus_rdata_en),
		.ctrl_valid		(w_ctrl_valid),
		.ctrl_ready		(w_ctrl_ready),
		.ctrl_rdata		(w_ctrl_rdata),
		.ctrl_rdata_en	(w_ctrl_rdata_en),
		.data_valid		(w_data_valid),
		.data_ready		(w_data_ready),
		.data_rdata		(w_data_rdata),
		.data_rdata_en	(w_data_rdata_en)
	);

	// ----------------------------------------------------------
	// port engines and vram
	// ----------------------------------------------------------
	vdp_ctrl_port u_ctrl (
		.clk85m, .arst_n,
		.req			(w_bus_req),
		.valid			(w_ctrl_valid),
		.ready			(w_ctrl_ready),
		.rdata			(w_ctrl_rdata),
		.rdata_en		(w_ctrl_rdata_en),
		.load			(w_load),
		.load_info		(w_load_info),
		.prefetch_busy	(w_prefetch_busy),
		.regs
	);

	vram_data_port u_data (
		.clk85m, .arst_n,
		.req			(w_bus_req),
		.valid			(w_data_valid),
		.ready			(w_data_ready),
		.rdata			(w_data_rdata),
		.rdata_en		(w_data_rdata_en),
		.load			(w_load),
		.load_info		(w_load_info),
		.prefetch_busy	(w_prefetch_busy),
		.vram_req		(w_vram_req),
		.vram_valid		(w_vram_valid),
		.vram_rdata		(w_vram_rdata),
		.vram_rdata_en	(w_vram_rdata_en)
	);

	vram_mem u_vram (
		.clk85m, .arst_n,
		.req			(w_vram_req),
		.valid			(w_vram_valid),
		.rdata			(w_vram_rdata),
		.rdata_en		(w_vram_rdata_en)
	);

endmodule

// ==== vram_data_port.sv ====
`timescale 1ns/1ps

module vram_data_port (
	input	logic							clk85m,
	input	logic							arst_n,
	input	vdp_cart_pkg::bus_req_t			req,
	input	logic							valid,
	output	logic							ready,
	output	logic	[7:0]					rdata,
	output	logic							rdata_en,
	input	logic							load,
	input	vdp_cart_pkg::vram_load_t		load_info,
	output	logic							prefetch_busy,
	output	vdp_cart_pkg::vram_req_t		vram_req,
	output	logic							vram_valid,
	input	logic	[7:0]					vram_rdata,
	input	logic							vram_rdata_en
);
	import vdp_cart_pkg::*;

	logic	[vram_addr_w-1:0]	ff_addr;		// auto-increment counter
	logic	[7:0]				ff_buf;			// read-ahead buffer
	logic						ff_inflight;	// one vram read out
	logic						ff_discard;		// write overtook the fill
	logic						ff_rd_wait;		// host read parked
	logic						ff_ready;
	logic						ff_rdata_en;
	logic	[7:0]				ff_rdata;
	vram_req_t					ff_vram_req;
	logic						ff_vram_valid;
	logic						wr_acc;
	logic						rd_acc;
	logic						rd_hit;
	logic						rd_late;
	logic						issue_rd;
	logic						issue_wr;
	logic	[vram_addr_w-1:0]	issue_addr;
	logic	[7:0]				fill_data;

	// ----------------------------------------------------------
	// access decode
	// ----------------------------------------------------------
	assign wr_acc		= valid & req.write & ~ff_ready;
	assign rd_acc		= valid & ~req.write & ~ff_ready & ~ff_rd_wait;
	assign rd_hit		= rd_acc & ~ff_inflight;				// buffer good
	assign rd_late		= vram_rdata_en & (ff_rd_wait | rd_acc);	// fill lands now
	assign issue_rd		= rd_hit | rd_late | (load & load_info.read_mode);
	assign issue_wr		= wr_acc;
	assign issue_addr	= load ? load_info.addr : ff_addr;
	assign fill_data	= ff_discard ? ff_buf : vram_rdata;	// keep written byte

	always_ff @(posedge clk85m or negedge arst_n) begin
		if (!arst_n) begin
			ff_addr			<= '0;
			ff_inflight		<= 1'b0;
			ff_discard		<= 1'b0;
			ff_rd_wait		<= 1'b0;
			ff_ready		<= 1'b0;
			ff_rdata_en		<= 1'b0;
			ff_vram_valid	<= 1'b0;
		end else begin
			ff_ready		<= wr_acc | rd_hit | rd_late;
			ff_rdata_en		<= rd_hit | rd_late;
			ff_vram_valid	<= issue_rd | issue_wr;
			if (load && !load_info.read_mode) begin
				ff_addr <= load_info.addr;				// write mode, no fetch
			end else if (issue_rd || issue_wr) begin
				ff_addr <= issue_addr + 1'b1;			// wraps at 128 KB
			end
			if (issue_rd) ff_inflight <= 1'b1;
			else if (vram_rdata_en) ff_inflight <= 1'b0;
			if (wr_acc && ff_inflight && !vram_rdata_en) ff_discard <= 1'b1;
			else if (vram_rdata_en) ff_discard <= 1'b0;
			if (rd_acc && ff_inflight && !vram_rdata_en) ff_rd_wait <= 1'b1;
			else if (rd_late) ff_rd_wait <= 1'b0;
		end
	end

	// ----------------------------------------------------------
	// buffer and vram request
	// ----------------------------------------------------------
	always_ff @(posedge clk85m) begin
		if (vram_rdata_en) ff_buf <= fill_data;
		if (wr_acc) ff_buf <= req.wdata;				// write wins
		if (rd_hit) ff_rdata <= ff_buf;
		else if (rd_late) ff_rdata <= fill_data;
		if (issue_rd || issue_wr) begin
			ff_vram_req <= '{addr: issue_addr, write: issue_wr, wdata: req.wdata};
		end
	end

	assign ready			= ff_ready;
	assign rdata			= ff_rdata;
	assign rdata_en			= ff_rdata_en;
	assign prefetch_busy	= ff_inflight;
	assign vram_req			= ff_vram_req;
	assign vram_valid		= ff_vram_valid;

endmodule

// ==== vram_mem.sv ====
`timescale 1ns/1ps

module vram_mem (
	input	logic						clk85m,
	input	logic						arst_n,
	input	vdp_cart_pkg::vram_req_t	req,
	input	logic						valid,
	output	logic	[7:0]				rdata,
	output	logic						rdata_en
);
	import vdp_cart_pkg::*;

	logic	[7:0]				mem [0:(1 << vram_addr_w) - 1];	// 128 KB
	logic	[vram_latency-1:0]	ff_vld;							// read pipe valid
	logic	[7:0]				ff_dat [vram_latency];

	always_ff @(posedge clk85m) begin
		if (valid && req.write) mem[req.addr] <= req.wdata;
	end

	always_ff @(posedge clk85m) begin
		if (valid) ff_dat[0] <= mem[req.addr];
		for (int i = 1; i < vram_latency; i++) begin
			ff_dat[i] <= ff_dat[i-1];
		end
	end

	always_ff @(posedge clk85m or negedge arst_n) begin
		if (!arst_n) begin
			ff_vld <= '0;
		end else begin
			ff_vld[0] <= valid & ~req.write;		// writes give no data
			for (int i = 1; i < vram_latency; i++) begin
				ff_vld[i] <= ff_vld[i-1];
			end
		end
	end

	assign rdata	= ff_dat[vram_latency-1];
	assign rdata_en	= ff_vld[vram_latency-1];

endmodule
